/* hw/mau_pkg.sv */
// Single hart only. RAM is 2 KiB at ram_base, and CLINT registers are matched on whole 8-byte words.
package mau_pkg;

	// ##############################
	// Widths and bank geometry
	localparam int xlen       = 64;
	localparam int num_banks  = 4;
	localparam int bank_words = 64;                     // Doublewords per bank.
	localparam int bank_sel_w = 2;                      // Address bits [4:3].
	localparam int word_idx_w = 6;                      // Address bits [10:5].

	// ##############################
	// Address map
	localparam logic [xlen-1:0] ram_base  = 64'h8000_0000;
	localparam logic [xlen-1:0] ram_bytes = 64'(num_banks * bank_words * 8);

	localparam logic [xlen-1:0] clint_msip_addr     = 64'h0200_0000;
	localparam logic [xlen-1:0] clint_mtimecmp_addr = 64'h0200_4000;
	localparam logic [xlen-1:0] clint_mtime_addr    = 64'h0200_BFF8;

	// Access targets carried from the decoder to the banks, CLINT and extractor
	localparam logic [2:0] tgt_none     = 3'd0;
	localparam logic [2:0] tgt_ram      = 3'd1;
	localparam logic [2:0] tgt_msip     = 3'd2;
	localparam logic [2:0] tgt_mtimecmp = 3'd3;
	localparam logic [2:0] tgt_mtime    = 3'd4;

	// ##############################
	// Opcodes and funct3 codes
	localparam logic [6:0] op_load  = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;

	localparam logic [2:0] f3_lb  = 3'b000;
	localparam logic [2:0] f3_lh  = 3'b001;
	localparam logic [2:0] f3_lw  = 3'b010;
	localparam logic [2:0] f3_ld  = 3'b011;
	localparam logic [2:0] f3_lbu = 3'b100;
	localparam logic [2:0] f3_lhu = 3'b101;
	localparam logic [2:0] f3_lwu = 3'b110;

	localparam logic [2:0] f3_sb = 3'b000;
	localparam logic [2:0] f3_sh = 3'b001;
	localparam logic [2:0] f3_sw = 3'b010;
	localparam logic [2:0] f3_sd = 3'b011;

endpackage

/* hw/access_decode.sv */
// Requester holds the fields stable until ack. Unsupported opcodes take the load path to no target.
`timescale 1ns/100ps

module access_decode import mau_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req,
	input  logic [6:0]            opcode,
	input  logic [2:0]            funct3,
	input  logic [xlen-1:0]       addr,
	input  logic [xlen-1:0]       wdata,
	output logic                  ack,
	output logic                  acc_stb,
	output logic                  resp_stb,
	output logic                  is_load,
	output logic [2:0]            tgt,
	output logic [bank_sel_w-1:0] bank_sel,
	output logic [word_idx_w-1:0] word_idx,
	output logic [2:0]            byte_off,
	output logic [2:0]            size_f3,
	output logic [7:0]            wmask,
	output logic [xlen-1:0]       wdata_sh
);

	typedef enum logic [1:0] {st_idle, st_busy, st_ack} state_t;

	state_t          state;
	logic [xlen-1:0] ram_off;
	logic            is_mem_op;
	logic [2:0]      tgt_d;
	logic [7:0]      mask_d;

	// ##############################
	// Address and mask decode
	always_comb begin
		ram_off   = addr - ram_base;
		is_mem_op = (opcode == op_load) || (opcode == op_store);
		if (!is_mem_op)                                    tgt_d = tgt_none;
		else if (ram_off < ram_bytes)                      tgt_d = tgt_ram;
		else if (addr[xlen-1:3] == clint_msip_addr[xlen-1:3])     tgt_d = tgt_msip;
		else if (addr[xlen-1:3] == clint_mtimecmp_addr[xlen-1:3]) tgt_d = tgt_mtimecmp;
		else if (addr[xlen-1:3] == clint_mtime_addr[xlen-1:3])    tgt_d = tgt_mtime;
		else                                               tgt_d = tgt_none;

		case (funct3)                                      // Bits past lane 7 fall off.
			f3_sb:   mask_d = 8'b0000_0001 << addr[2:0];
			f3_sh:   mask_d = 8'b0000_0011 << addr[2:0];
			f3_sw:   mask_d = 8'b0000_1111 << addr[2:0];
			f3_sd:   mask_d = 8'b1111_1111 << addr[2:0];
			default: mask_d = 8'h00;
		endcase
		if (opcode != op_store) begin
			mask_d = 8'h00;
		end
	end

	// ##############################
	// Four-phase handshake controller
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= st_idle;
			acc_stb  <= 1'b0;
			resp_stb <= 1'b0;
		end else begin
			acc_stb <= 1'b0;
			case (state)
				st_idle: if (req) begin
					acc_stb <= 1'b1;                           // Edge E0.
					state   <= st_busy;
				end
				st_busy: begin
					resp_stb <= !resp_stb;                     // Pulse at E1, drop at E2.
					if (resp_stb) state <= st_ack;
				end
				default: if (!req) state <= st_idle;
			endcase
		end
	end

	assign ack = (state == st_ack);

	always_ff @(posedge clk) begin
		if (state == st_idle && req) begin
			is_load  <= (opcode != op_store);
			tgt      <= tgt_d;
			bank_sel <= ram_off[3 +: bank_sel_w];
			word_idx <= ram_off[3 + bank_sel_w +: word_idx_w];
			byte_off <= addr[2:0];
			size_f3  <= funct3;
			wmask    <= mask_d;
			wdata_sh <= wdata << {addr[2:0], 3'b000};     // Data into its lanes.
		end
	end

endmodule

/* hw/mem_bank.sv */
// Single-port bank with byte enables; rdata returns the word as it was before the write.
`timescale 1ns/100ps

module mem_bank import mau_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stb,
	input  logic [7:0]            wmask,
	input  logic [word_idx_w-1:0] word_idx,
	input  logic [xlen-1:0]       wdata,
	output logic [xlen-1:0]       rdata
);

	logic [xlen-1:0] mem [bank_words];

	// ##############################
	// Byte-lane write
	always_ff @(posedge clk) begin
		if (stb) begin
			for (int b = 0; b < xlen / 8; b++) begin
				if (wmask[b]) begin
					mem[word_idx][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
		end
	end

	// Registered read port.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (stb) begin
			rdata <= mem[word_idx];                           // Old contents on a store.
		end
	end

endmodule

/* hw/clint.sv */
// Single-hart CLINT; mtime counts every clock and registers are written only through byte lanes.
`timescale 1ns/100ps

module clint import mau_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stb,
	input  logic [2:0]      tgt,
	input  logic [7:0]      wmask,
	input  logic [xlen-1:0] wdata,
	output logic [xlen-1:0] rdata,
	output logic            msip,
	output logic            mtip
);

	logic [xlen-1:0] mtime;
	logic [xlen-1:0] mtimecmp;
	logic            wr;

	function automatic logic [xlen-1:0] merge_lanes(
		input logic [xlen-1:0] old_v,
		input logic [xlen-1:0] new_v,
		input logic [7:0]      mask
	);
		logic [xlen-1:0] res;
		res = old_v;
		for (int b = 0; b < xlen / 8; b++) begin
			if (mask[b]) begin
				res[b*8 +: 8] = new_v[b*8 +: 8];
			end
		end
		return res;
	endfunction

	assign wr = stb && (|wmask);                          // Only stores carry a mask.

	// ##############################
	// Timer and software interrupt
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime    <= '0;
			mtimecmp <= '1;
			msip     <= 1'b0;
			rdata    <= '0;
		end else begin
			if (wr && tgt == tgt_mtime) mtime <= merge_lanes(mtime, wdata, wmask);
			else                        mtime <= mtime + 1'b1;
			if (wr && tgt == tgt_mtimecmp) mtimecmp <= merge_lanes(mtimecmp, wdata, wmask);
			if (wr && tgt == tgt_msip && wmask[0]) msip <= wdata[0];
			if (stb) begin
				case (tgt)
					tgt_msip:     rdata <= {{(xlen-1){1'b0}}, msip};
					tgt_mtimecmp: rdata <= mtimecmp;
					tgt_mtime:    rdata <= mtime;
					default:      rdata <= '0;
				endcase
			end
		end
	end

	assign mtip = (mtime >= mtimecmp);

endmodule

/* hw/load_extract.sv */
// Lane groups that run past byte 7 read as zero. ld_data holds until the next load response.
`timescale 1ns/100ps

module load_extract import mau_pkg::*; (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           resp_stb,
	input  logic                           is_load,
	input  logic [2:0]                     tgt,
	input  logic [bank_sel_w-1:0]          bank_sel,
	input  logic [2:0]                     byte_off,
	input  logic [2:0]                     size_f3,
	input  logic [num_banks-1:0][xlen-1:0] bank_rdata,
	input  logic [xlen-1:0]                clint_rdata,
	output logic [xlen-1:0]                ld_data
);

	logic [xlen-1:0] word;
	logic [xlen-1:0] shifted;
	logic [7:0]      b8;
	logic [15:0]     h16;
	logic [31:0]     w32;
	logic [xlen-1:0] d64;
	logic [xlen-1:0] ext;

	// ##############################
	// Source select and lane extraction
	always_comb begin
		case (tgt)
			tgt_ram:                           word = bank_rdata[bank_sel];
			tgt_msip, tgt_mtimecmp, tgt_mtime: word = clint_rdata;
			default:                           word = '0;
		endcase
		shifted = word >> {byte_off, 3'b000};
		b8      = shifted[7:0];
		h16     = (byte_off <= 3'd6) ? shifted[15:0] : 16'h0;
		w32     = (byte_off <= 3'd4) ? shifted[31:0] : 32'h0;
		d64     = (byte_off == 3'd0) ? word : '0;

		case (size_f3)
			f3_lb:   ext = {{(xlen-8){b8[7]}}, b8};
			f3_lh:   ext = {{(xlen-16){h16[15]}}, h16};
			f3_lw:   ext = {{(xlen-32){w32[31]}}, w32};
			f3_ld:   ext = d64;
			f3_lbu:  ext = {{(xlen-8){1'b0}}, b8};
			f3_lhu:  ext = {{(xlen-16){1'b0}}, h16};
			f3_lwu:  ext = {{(xlen-32){1'b0}}, w32};
			default: ext = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_data <= '0;
		end else if (resp_stb && is_load) begin
			ld_data <= ext;                                   // Edge E2.
		end
	end

endmodule

/* hw/mau_top.sv */
// One access per four-phase req/ack handshake; ack rises two edges after req is first sampled.
`timescale 1ns/100ps

module mau_top import mau_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            req,
	input  logic [6:0]      opcode,
	input  logic [2:0]      funct3,
	input  logic [xlen-1:0] addr,
	input  logic [xlen-1:0] wdata,
	output logic            ack,
	output logic [xlen-1:0] ld_data,
	output logic            msip,
	output logic            mtip
);

	logic                           acc_stb;
	logic                           resp_stb;
	logic                           is_load;
	logic [2:0]                     tgt;
	logic [bank_sel_w-1:0]          bank_sel;
	logic [word_idx_w-1:0]          word_idx;
	logic [2:0]                     byte_off;
	logic [2:0]                     size_f3;
	logic [7:0]                     wmask;
	logic [xlen-1:0]                wdata_sh;
	logic [num_banks-1:0][xlen-1:0] bank_rdata;
	logic [xlen-1:0]                clint_rdata;

	access_decode access_decode_inst (
		.clk(clk), .rst_n(rst_n), .req(req), .opcode(opcode), .funct3(funct3),
		.addr(addr), .wdata(wdata), .ack(ack), .acc_stb(acc_stb), .resp_stb(resp_stb),
		.is_load(is_load), .tgt(tgt), .bank_sel(bank_sel), .word_idx(word_idx),
		.byte_off(byte_off), .size_f3(size_f3), .wmask(wmask), .wdata_sh(wdata_sh)
	);

	// ##############################
	// Interleaved RAM banks
	for (genvar i = 0; i < num_banks; i++) begin : g_bank
		wire bank_stb = acc_stb && (tgt == tgt_ram) && (bank_sel == bank_sel_w'(i));

		mem_bank mem_bank_inst (
			.clk(clk), .rst_n(rst_n), .stb(bank_stb), .wmask(wmask),
			.word_idx(word_idx), .wdata(wdata_sh), .rdata(bank_rdata[i])
		);
	end

	clint clint_inst (
		.clk(clk), .rst_n(rst_n), .stb(acc_stb), .tgt(tgt), .wmask(wmask),
		.wdata(wdata_sh), .rdata(clint_rdata), .msip(msip), .mtip(mtip)
	);

	load_extract load_extract_inst (
		.clk(clk), .rst_n(rst_n), .resp_stb(resp_stb), .is_load(is_load), .tgt(tgt),
		.bank_sel(bank_sel), .byte_off(byte_off), .size_f3(size_f3),
		.bank_rdata(bank_rdata), .clint_rdata(clint_rdata), .ld_data(ld_data)
	);

endmodule

/* dv/mau_checker.sv */
// Loaded RAM words must be stored first; mtip is checked only while mtimecmp is zero or all ones.
`timescale 1ns/100ps

module mau_checker import mau_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            req,
	input  logic [6:0]      opcode,
	input  logic [2:0]      funct3,
	input  logic [xlen-1:0] addr,
	input  logic [xlen-1:0] wdata,
	input  logic            ack,
	input  logic [xlen-1:0] ld_data,
	input  logic            msip,
	input  logic            mtip,
	input  int              test_id,
	input  logic            test_done,
	input  logic            all_done,
	output int              err_count
);

	logic [xlen-1:0] shadow_ram [num_banks * bank_words];
	logic [xlen-1:0] shadow_mtimecmp;
	logic            shadow_msip;
	logic [xlen-1:0] last_ld;
	logic            ack_q;
	logic            req_q;
	logic            pending;
	int              edge_cnt;
	int              check_count;
	int              test_checks;
	int              test_errs;
	int              failed_tests;

	initial begin
		shadow_mtimecmp = '1;                              // Reset value of the compare register.
		shadow_msip     = 1'b0;
		last_ld         = '0;
		ack_q           = 1'b0;
		req_q           = 1'b0;
		pending         = 1'b0;
		edge_cnt        = 0;
		err_count       = 0;
		check_count     = 0;
		test_checks     = 0;
		test_errs       = 0;
		failed_tests    = 0;
	end

	function automatic string test_name(input int id);
		case (id)
			1:       return "doubleword round trip";
			2:       return "sub-word stores";
			3:       return "load extension";
			4:       return "handshake";
			5:       return "interruptor";
			6:       return "unmapped and unsupported";
			default: return "unknown";
		endcase
	endfunction

	function automatic logic in_ram(input logic [xlen-1:0] a);
		return (a >= ram_base) && (a < ram_base + ram_bytes);
	endfunction

	function automatic int ram_index(input logic [xlen-1:0] a);
		return int'((a - ram_base) >> 3);
	endfunction

	// ##############################
	// Reference model
	function automatic logic [xlen-1:0] expected_load(input logic [xlen-1:0] a,
		input logic [2:0] f3);
		logic [xlen-1:0] word;
		logic [xlen-1:0] raw;
		logic [xlen-1:0] keep;
		int              n;
		int              off;
		word = '0;
		if (in_ram(a)) word = shadow_ram[ram_index(a)];
		else if (a[xlen-1:3] == clint_msip_addr[xlen-1:3]) word = {63'b0, shadow_msip};
		else if (a[xlen-1:3] == clint_mtimecmp_addr[xlen-1:3]) word = shadow_mtimecmp;
		n   = 1 << f3[1:0];
		off = int'(a[2:0]);
		if (f3 == 3'b111 || off + n > 8) return '0;        // Crosses the doubleword.
		raw  = word >> (off * 8);
		keep = (n == 8) ? '1 : ((64'd1 << (n * 8)) - 1);
		raw  = raw & keep;
		if (!f3[2] && raw[n*8-1]) raw = raw | ~keep;       // Sign extension.
		return raw;
	endfunction

	task automatic mirror_store(input logic [xlen-1:0] a, input logic [2:0] f3,
		input logic [xlen-1:0] d);
		logic [15:0]     lanes;
		logic [xlen-1:0] sh;
		logic [xlen-1:0] word;
		lanes = ((16'd1 << (1 << f3[1:0])) - 1) << a[2:0];
		sh    = d << (int'(a[2:0]) * 8);
		if (f3[2]) return;
		word = in_ram(a) ? shadow_ram[ram_index(a)] : shadow_mtimecmp;
		for (int b = 0; b < 8; b++) begin
			if (lanes[b]) word[b*8 +: 8] = sh[b*8 +: 8];
		end
		if (in_ram(a)) shadow_ram[ram_index(a)] = word;
		else if (a[xlen-1:3] == clint_mtimecmp_addr[xlen-1:3]) shadow_mtimecmp = word;
		else if (a[xlen-1:3] == clint_msip_addr[xlen-1:3] && lanes[0]) shadow_msip = sh[0];
	endtask

	task automatic note_error();
		err_count++;
		test_errs++;
	endtask

	task automatic complete_access();
		logic [xlen-1:0] exp;
		if (opcode == op_store) begin
			mirror_store(addr, funct3, wdata);
			check_count++;
			test_checks++;
			if (ld_data !== last_ld) begin                 // Holds until the next load.
				$display("Error at %0t: store changed ld_data, expected %h, got %h",
					$time, last_ld, ld_data);
				note_error();
			end
		end else begin
			exp = (opcode == op_load) ? expected_load(addr, funct3) : '0;
			last_ld = exp;
			check_count++;
			test_checks++;
			if (ld_data !== exp) begin
				$display("Error at %0t: op %b funct3 %0d addr %h expected %h, got %h",
					$time, opcode, funct3, addr, exp, ld_data);
				note_error();
			end
		end
		check_count++;
		test_checks++;
		if (msip !== shadow_msip) begin
			$display("Error at %0t: msip expected %b, got %b", $time, shadow_msip, msip);
			note_error();
		end
		if ((shadow_mtimecmp == '0 && mtip !== 1'b1) ||
			(shadow_mtimecmp == '1 && mtip !== 1'b0)) begin
			$display("Error at %0t: mtip is %b with mtimecmp %h", $time, mtip, shadow_mtimecmp);
			note_error();
		end
	endtask

	// ##############################
	// Handshake watch and compare
	always @(posedge clk) begin
		if (!rst_n) begin
			if (ack !== 1'b0) begin
				$display("Handshake fault at %0t: ack is high during reset", $time);
				note_error();
			end
		end else begin
			if (!pending && !ack && req) begin
				pending  = 1'b1;                           // Edge E0.
				edge_cnt = 0;
			end else if (pending) begin
				edge_cnt++;
			end
			if (ack && !ack_q) begin
				if (edge_cnt != 3) begin
					$display("Handshake fault at %0t: ack rose %0d edges after req, not 2",
						$time, edge_cnt - 1);
					note_error();
				end
				pending = 1'b0;
				complete_access();
			end
			if (ack_q && req_q && !ack) begin
				$display("Handshake fault at %0t: ack fell while req was still high", $time);
				note_error();
			end
			if (ack_q && !req_q && ack) begin
				$display("Handshake fault at %0t: ack stayed high after req dropped", $time);
				note_error();
			end
		end
		ack_q = ack;
		req_q = req;
	end

	always @(posedge test_done) begin
		$display("Test %0d (%s): %0d checks, %0d errors", test_id, test_name(test_id),
			test_checks, test_errs);
		if (test_errs != 0) failed_tests++;
		test_checks = 0;
		test_errs   = 0;
	end

	always @(posedge all_done) begin
		$display("Checks: %0d, errors: %0d, tests with errors: %0d", check_count, err_count,
			failed_tests);
	end

endmodule

/* dv/tb_mau.sv */
// Requests follow the four-phase rule; mtime is never loaded because its value depends on the cycle count.
`timescale 1ns/100ps

module tb_mau import mau_pkg::*; ();

	localparam int n_words    = num_banks * bank_words;
	localparam int n_sub      = 48;
	localparam int n_unmapped = 8;
	localparam int total_txn  = 2 * n_words + 2 * n_sub + 29 * num_banks + 4 + 8
		+ 5 * n_unmapped + 4;

	logic            clk;
	logic            rst_n;
	logic            req;
	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [xlen-1:0] addr;
	logic [xlen-1:0] wdata;
	logic            ack;
	logic [xlen-1:0] ld_data;
	logic            msip;
	logic            mtip;
	int              test_id;
	logic            test_done;
	logic            all_done;
	int              err_count;
	logic [31:0]     rng_state;

	mau_top mau_top_inst (
		.clk(clk), .rst_n(rst_n), .req(req), .opcode(opcode), .funct3(funct3), .addr(addr),
		.wdata(wdata), .ack(ack), .ld_data(ld_data), .msip(msip), .mtip(mtip)
	);

	mau_checker mau_checker_inst (
		.clk(clk), .rst_n(rst_n), .req(req), .opcode(opcode), .funct3(funct3), .addr(addr),
		.wdata(wdata), .ack(ack), .ld_data(ld_data), .msip(msip), .mtip(mtip),
		.test_id(test_id), .test_done(test_done), .all_done(all_done), .err_count(err_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		repeat (total_txn * 12 + 200) @(posedge clk);
		$display("Run hung: tests did not finish within %0d cycles", total_txn * 12 + 200);
		$display("tests failed");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		hi = next_rand();
		return {hi, next_rand()};
	endfunction

	// ##############################
	// Four-phase driver
	task automatic do_access(input logic [6:0] op, input logic [2:0] f3,
		input logic [xlen-1:0] a, input logic [xlen-1:0] d, input int hold);
		@(posedge clk);
		req    <= 1'b1;
		opcode <= op;
		funct3 <= f3;
		addr   <= a;
		wdata  <= d;
		do @(posedge clk); while (!ack);
		repeat (hold) @(posedge clk);                      // Extra cycles of back-pressure.
		req <= 1'b0;
		do @(posedge clk); while (ack);
	endtask

	task automatic finish_test();
		test_done <= 1'b1;
		@(posedge clk);
		test_done <= 1'b0;
	endtask

	initial begin
		logic [xlen-1:0] a;
		logic [31:0]     r;
		logic [2:0]      f3;
		logic [2:0]      off;
		int              i;
		int              k;
		int              b;
		rng_state  = 32'h9789b039;
		test_id    = 0;
		rst_n     <= 1'b0;
		req       <= 1'b0;
		opcode    <= '0;
		funct3    <= '0;
		addr      <= '0;
		wdata     <= '0;
		test_done <= 1'b0;
		all_done  <= 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		test_id = 1;
		for (i = 0; i < n_words; i++) begin
			do_access(op_store, f3_sd, ram_base + 64'(i * 8), rand64(), 0);
		end
		for (i = 0; i < n_words; i++) begin
			do_access(op_load, f3_ld, ram_base + 64'(((i * 37) % n_words) * 8), '0, 0);
		end
		finish_test();

		test_id = 2;
		for (i = 0; i < n_sub; i++) begin
			r   = next_rand();
			f3  = 3'(r % 3);                               // SB, SH or SW.
			off = r[5:3] & (3'b111 << f3);
			a   = ram_base + {r[13:6], off};
			do_access(op_store, f3, a, rand64(), 0);
			do_access(op_load, f3_ld, {a[xlen-1:3], 3'b000}, '0, 0);
		end
		finish_test();

		test_id = 3;
		for (i = 0; i < num_banks; i++) begin
			r = next_rand();
			a = ram_base + {r[5:0], 2'(i), 3'b000};
			do_access(op_store, f3_sd, a, rand64(), 0);
			for (k = 0; k < 7; k++) begin
				if (k != 3) begin
					for (b = 0; b < 8; b += 1 << (k % 4)) begin
						do_access(op_load, 3'(k), a + 64'(b), '0, 0);
					end
				end
			end
		end
		finish_test();

		test_id = 4;
		do_access(op_store, f3_sd, ram_base + 64'h40, rand64(), 3);
		do_access(op_load, f3_ld, ram_base + 64'h40, '0, 2);
		do_access(op_load, f3_lw, ram_base + 64'h44, '0, 1);
		do_access(op_store, f3_sb, ram_base + 64'h41, rand64(), 0);
		finish_test();

		test_id = 5;
		do_access(op_store, f3_sd, clint_msip_addr, 64'h1, 0);
		do_access(op_load, f3_ld, clint_msip_addr, '0, 0);
		do_access(op_store, f3_sw, clint_msip_addr, 64'h0, 0);
		do_access(op_load, f3_ld, clint_msip_addr, '0, 0);
		do_access(op_store, f3_sd, clint_mtimecmp_addr, 64'h0, 0);
		do_access(op_store, f3_sd, clint_mtimecmp_addr, '1, 0);
		do_access(op_store, f3_sd, clint_mtimecmp_addr, rand64() | 64'h8000_0000_0000_0000, 0);
		do_access(op_load, f3_ld, clint_mtimecmp_addr, '0, 0);
		finish_test();

		test_id = 6;
		for (i = 0; i < n_unmapped; i++) begin
			r = next_rand();
			do_access(op_load, 3'(r % 7), rand64() | 64'h0000_0100_0000_0000, '0, 0);
			do_access(op_store, f3_sd, ram_base + ram_bytes + 64'(i * 8), rand64(), 0);
			do_access(op_store, f3_sd, ram_base - 64'(8 + i * 8), rand64(), 0);
			do_access(op_load, f3_ld, ram_base + 64'(i * 8), '0, 0);
			do_access(op_load, f3_ld, ram_base + ram_bytes - 64'(8 + i * 8), '0, 0);
		end
		do_access(7'b0110011, f3_ld, ram_base, rand64(), 0);
		do_access(7'b0010011, f3_lw, ram_base + 64'h8, rand64(), 0);
		do_access(7'b1101111, f3_sd, ram_base + 64'h10, rand64(), 0);
		do_access(7'b0000000, f3_lb, clint_msip_addr, rand64(), 0);
		finish_test();

		all_done <= 1'b1;
		@(posedge clk);
		if (err_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
hw/mau_pkg.sv
hw/access_decode.sv
hw/mem_bank.sv
hw/clint.sv
hw/load_extract.sv
hw/mau_top.sv
dv/mau_checker.sv
dv/tb_mau.sv
